// ==== build.f ====
+incdir+include
hw/video_pkg.sv
hw/raster_counter.sv
hw/output_sequencer.sv
hw/line_reader.sv
hw/sync_generator.sv
hw/pixel_output.sv
hw/ram2video.sv
sim/tb_ram2video.sv

// ==== hw/line_reader.sv ====
`timescale 1ns/1ps
`include "video_params.svh"

module line_reader
    import video_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          run,
    input  video_config_t cfg,
    input  raster_pos_t   pos,
    output ram_addr_t     rdaddr
);

    localparam int REP_W = $clog2(`PIXEL_REPEAT + 1);

    logic [REP_W-1:0] rep_cnt;
    logic [REP_W-1:0] rep_cur;
    ram_addr_t        col;
    ram_addr_t        col_cur;
    ram_addr_t        row_base;
    ram_addr_t        base_cur;
    logic [`ADDR_W:0] base_step;
    logic             line_start;
    logic             first_line;

    ////////////////////////////////////////////////////////////////////////////
    // counter values that apply to the current raster position

    // one buffer line per output line pair
    assign line_start = (pos.x == cfg.h_capture_start)
                     && (pos.y >= cfg.v_capture_start)
                     && !pos.y[0];
    assign first_line = (pos.y == cfg.v_capture_start);
    assign base_step  = {1'b0, row_base} + {1'b0, cfg.line_length};

    always_comb begin
        rep_cur  = rep_cnt;
        col_cur  = col;
        base_cur = row_base;
        if (line_start) begin
            rep_cur = '0;
            col_cur = '0;
            if (first_line) begin
                base_cur = '0;
            end else if (base_step >= {1'b0, cfg.ram_words}) begin
                // wrap at the end of the buffer
                base_cur = '0;
            end else begin
                base_cur = base_step[`ADDR_W-1:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // state update and address register

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rep_cnt  <= '0;
            col      <= '0;
            row_base <= '0;
            rdaddr   <= '0;
        end else if (!run) begin
            rep_cnt  <= '0;
            col      <= '0;
            row_base <= '0;
            rdaddr   <= '0;
        end else begin
            row_base <= base_cur;
            rdaddr   <= base_cur + col_cur;
            if (rep_cur == REP_W'(`PIXEL_REPEAT - 1)) begin
                rep_cnt <= '0;
                col     <= (col_cur == cfg.line_length - 1'b1) ? '0 : col_cur + 1'b1;
            end else begin
                rep_cnt <= rep_cur + 1'b1;
                col     <= col_cur;
            end
        end
    end

endmodule

// ==== hw/output_sequencer.sv ====
`timescale 1ns/1ps
`include "video_params.svh"

module output_sequencer
    import video_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  logic frame_start,
    output logic run,
    output logic show,
    output logic full_cycle
);

    localparam int CNT_W = $clog2(`WARMUP_FRAMES + 1);

    seq_state_t       state;
    logic [CNT_W-1:0] frame_cnt;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= SEQ_IDLE;
            frame_cnt  <= '0;
            full_cycle <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        state     <= SEQ_WARMUP;
                        frame_cnt <= '0;
                    end
                end
                SEQ_WARMUP: begin
                    // first pulse ends the partial frame after start
                    if (frame_start) begin
                        if (frame_cnt == CNT_W'(`WARMUP_FRAMES - 1)) begin
                            state      <= SEQ_ACTIVE;
                            full_cycle <= 1'b1;
                        end else begin
                            frame_cnt <= frame_cnt + 1'b1;
                        end
                    end
                end
                SEQ_ACTIVE: begin
                    // only reset leaves this state
                    state <= SEQ_ACTIVE;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    assign run  = (state != SEQ_IDLE);
    assign show = (state == SEQ_ACTIVE);

endmodule

// ==== hw/pixel_output.sv ====
`timescale 1ns/1ps

module pixel_output
    import video_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  video_config_t cfg,
    input  raster_pos_t   pos,
    input  logic          show,
    input  pixel_t        rddata,
    output video_out_t    video
);

    raster_pos_t pos_d1;
    raster_pos_t pos_d2;
    logic        in_window;
    logic        in_visible;

    // match the address register and RAM read delay
    always_ff @(posedge clock) begin
        pos_d1 <= pos;
        pos_d2 <= pos_d1;
    end

    assign in_window = (pos_d2.x >= cfg.h_capture_start)
                    && (pos_d2.x < cfg.h_capture_end)
                    && (pos_d2.y >= cfg.v_capture_start)
                    && (pos_d2.y < cfg.v_capture_end);

    assign in_visible = (pos_d2.x < cfg.h_visible) && (pos_d2.y < cfg.v_visible);

    ////////////////////////////////////////////////////////////////////////////
    // output register for pixel and draw area only

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            video <= '0;
        end else begin
            video.pixel     <= (show && in_window) ? rddata : '0;
            video.draw_area <= show && in_visible;
            video.hsync     <= 1'b0;
            video.vsync     <= 1'b0;
        end
    end

endmodule

// ==== hw/ram2video.sv ====
`timescale 1ns/1ps

module ram2video
    import video_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          start,
    input  video_config_t cfg,

    // line buffer read port
    output ram_addr_t     rdaddr,
    input  pixel_t        rddata,

    // video out
    output pixel_t        video_out,
    output logic          hsync,
    output logic          vsync,
    output logic          draw_area,
    output logic          full_cycle
);

    logic        run;
    logic        show;
    logic        frame_start;
    raster_pos_t pos;
    video_out_t  video;

    output_sequencer u_sequencer (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .frame_start (frame_start),
        .run         (run),
        .show        (show),
        .full_cycle  (full_cycle)
    );

    raster_counter u_raster (
        .clock       (clock),
        .reset       (reset),
        .run         (run),
        .cfg         (cfg),
        .pos         (pos),
        .frame_start (frame_start)
    );

    line_reader u_reader (
        .clock  (clock),
        .reset  (reset),
        .run    (run),
        .cfg    (cfg),
        .pos    (pos),
        .rdaddr (rdaddr)
    );

    sync_generator u_sync (
        .clock (clock),
        .reset (reset),
        .cfg   (cfg),
        .pos   (pos),
        .show  (show),
        .hsync (hsync),
        .vsync (vsync)
    );

    pixel_output u_pixel (
        .clock  (clock),
        .reset  (reset),
        .cfg    (cfg),
        .pos    (pos),
        .show   (show),
        .rddata (rddata),
        .video  (video)
    );

    assign video_out = video.pixel;
    assign draw_area = video.draw_area;

endmodule

// ==== hw/raster_counter.sv ====
`timescale 1ns/1ps

module raster_counter
    import video_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          run,
    input  video_config_t cfg,
    output raster_pos_t   pos,
    output logic          frame_start
);

    coord_t v_total;
    logic   x_wrap;
    logic   y_wrap;

    // odd and even fields may differ by a line
    assign v_total = pos.field ? cfg.v_total_2 : cfg.v_total_1;

    assign x_wrap = (pos.x == cfg.h_total - 1'b1);
    assign y_wrap = (pos.y == v_total - 1'b1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pos         <= '0;
            frame_start <= 1'b0;
        end else if (!run) begin
            // park on the capture corner until started
            pos.x       <= cfg.h_capture_start;
            pos.y       <= cfg.v_capture_start;
            pos.field   <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            // registered so it is high exactly while pos is 0,0
            frame_start <= x_wrap && y_wrap;

            if (x_wrap) begin
                pos.x <= '0;
                if (y_wrap) begin
                    pos.y     <= '0;
                    pos.field <= ~pos.field;
                end else begin
                    pos.y <= pos.y + 1'b1;
                end
            end else begin
                pos.x <= pos.x + 1'b1;
            end
        end
    end

endmodule

// ==== hw/sync_generator.sv ====
`timescale 1ns/1ps
`include "video_params.svh"

module sync_generator
    import video_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  video_config_t cfg,
    input  raster_pos_t   pos,
    input  logic          show,
    output logic          hsync,
    output logic          vsync
);

    localparam int LAT = `OUT_LATENCY;

    logic [`COORD_W:0]   h_end;
    logic [`COORD_W:0]   v_end;
    logic                h_on;
    logic                v_on;
    // bit 1 hsync active, bit 0 vsync active
    logic [LAT-1:0][1:0] act_pipe;

    // one extra bit so the end of the pulse cannot overflow
    assign h_end = {1'b0, cfg.h_sync_start} + {1'b0, cfg.h_sync_width};
    assign v_end = {1'b0, cfg.v_sync_start} + {1'b0, cfg.v_sync_width};

    assign h_on = (pos.x >= cfg.h_sync_start) && ({1'b0, pos.x} < h_end);
    assign v_on = (pos.y >= cfg.v_sync_start) && ({1'b0, pos.y} < v_end);

    ////////////////////////////////////////////////////////////////////////////
    // delay to line up with the pixel path

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            act_pipe <= '0;
        end else begin
            act_pipe[0] <= {h_on, v_on};
            for (int i = 1; i < LAT - 1; i++) begin
                act_pipe[i] <= act_pipe[i-1];
            end
            // last stage blanks alongside the pixel path
            act_pipe[LAT-1] <= show ? act_pipe[LAT-2] : 2'b00;
        end
    end

    // polarity from the static config
    assign hsync = act_pipe[LAT-1][1] ? cfg.h_sync_on : ~cfg.h_sync_on;
    assign vsync = act_pipe[LAT-1][0] ? cfg.v_sync_on : ~cfg.v_sync_on;

endmodule

// ==== hw/video_pkg.sv ====
`include "video_params.svh"

package video_pkg;

    typedef logic [`COORD_W-1:0] coord_t;
    typedef logic [`ADDR_W-1:0]  ram_addr_t;
    typedef logic [`PIXEL_W-1:0] pixel_t;

    // static timing set held steady while the engine runs
    typedef struct packed {
        coord_t    h_total;
        coord_t    h_visible;
        coord_t    h_sync_start;
        coord_t    h_sync_width;
        coord_t    h_capture_start;
        coord_t    h_capture_end;
        coord_t    v_total_1;
        coord_t    v_total_2;
        coord_t    v_visible;
        coord_t    v_sync_start;
        coord_t    v_sync_width;
        coord_t    v_capture_start;
        coord_t    v_capture_end;
        logic      h_sync_on;
        logic      v_sync_on;
        ram_addr_t line_length;
        ram_addr_t ram_words;
    } video_config_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   field;
    } raster_pos_t;

    typedef struct packed {
        pixel_t pixel;
        logic   hsync;
        logic   vsync;
        logic   draw_area;
    } video_out_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WARMUP,
        SEQ_ACTIVE
    } seq_state_t;

endpackage

// ==== include/video_params.svh ====
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// raster coordinate, buffer address and colour widths
`define COORD_W 12
`define ADDR_W 14
`define PIXEL_W 24

// output clocks spent on each RAM word
`define PIXEL_REPEAT 4

// frames kept dark after start
`define WARMUP_FRAMES 3

// clocks from raster position to the output pins
`define OUT_LATENCY 3

`endif

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and judge the result from the log

rm -f sim.log

verilator --binary --timing --assert -f build.f --top-module tb_ram2video \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1

grep -q "^NO ERRORS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== sim/tb_ram2video.sv ====
`timescale 1ns/1ps
`include "video_params.svh"

module tb_ram2video
    import video_pkg::*;
();

    localparam int H_TOTAL = 40;
    localparam int H_VIS = 32;
    localparam int H_SYNC_START = 34;
    localparam int H_SYNC_W = 3;
    localparam int H_CAP_START = 4;
    localparam int H_CAP_END = 28;
    localparam int V1 = 20;
    localparam int V2 = 21;
    localparam int V_SYNC_W = 2;
    localparam int V_CAP_START = 2;
    localparam int V_CAP_END = 14;
    localparam int L = 6;
    localparam int WORDS = 24;
    localparam int REP = `PIXEL_REPEAT;
    localparam logic [9:0] TAG = 10'h2a5;
    // clocks from an hsync leading edge to x = 0 and to the window start
    localparam int DA_OFFSET = H_TOTAL - H_SYNC_START;
    localparam int SEG_OFFSET = H_TOTAL - H_SYNC_START + H_CAP_START;

    logic          clock;
    logic          reset;
    logic          start;
    video_config_t cfg;
    ram_addr_t     rdaddr;
    pixel_t        rddata = '0;
    pixel_t        video_out;
    logic          hsync;
    logic          vsync;
    logic          draw_area;
    logic          full_cycle;

    int    seed = 32'hde72;
    int    err[6];
    int    obs[6];
    string names[6];
    int    cyc;
    logic  counting;
    logic  fc_seen = 1'b0;
    int    now;
    logic  hs_prev = 1'b0;
    logic  vs_prev = 1'b0;
    logic  da_prev = 1'b0;
    logic  px_prev_nz = 1'b0;
    logic  hs_have = 1'b0;
    logic  vs_have = 1'b0;
    logic  da_valid = 1'b0;
    int    hs_edge, hs_len, vs_edge, vs_len, vs_gap_prev, da_len;
    int    px_addr, run_len, seg_len, seg_k;

    ram2video dut (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .cfg        (cfg),
        .rdaddr     (rdaddr),
        .rddata     (rddata),
        .video_out  (video_out),
        .hsync      (hsync),
        .vsync      (vsync),
        .draw_area  (draw_area),
        .full_cycle (full_cycle)
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    // line buffer model tags each word with its address
    always @(posedge clock) begin
        rddata <= {TAG, rdaddr};
    end

    always @(posedge clock) begin
        if (counting) begin
            cyc <= cyc + 1;
        end
    end

    // partial field after start, then whole fields up to the last warm-up pulse
    function automatic int warmup_cycles();
        int total;
        int fld;
        total = H_TOTAL * V1 - (V_CAP_START * H_TOTAL + H_CAP_START);
        fld = 1;
        for (int i = 1; i < `WARMUP_FRAMES; i++) begin
            total += H_TOTAL * ((fld == 1) ? V2 : V1);
            fld = 1 - fld;
        end
        return total + 1;
    endfunction

    task automatic note_mismatch(input int t, input int expected, input int actual);
        $display("FAIL %s expected %0d actual %0d", names[t], expected, actual);
        err[t]++;
    endtask

    task automatic flag_error(input int t, input string what);
        $display("ERROR in %s: %s", names[t], what);
        err[t]++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output monitor

    always @(negedge clock) begin
        logic hs_act;
        logic vs_act;
        int   addr;
        int   exp_addr;
        hs_act = (hsync == cfg.h_sync_on);
        vs_act = (vsync == cfg.v_sync_on);
        addr = int'(video_out[13:0]);
        now++;
        if (!reset && !full_cycle) begin
            obs[0]++;
            assert (video_out == '0) else note_mismatch(0, 0, int'(video_out));
            assert (!draw_area) else flag_error(0, "draw_area high while blanked");
            assert (!hs_act) else flag_error(0, "hsync left its off level while blanked");
            assert (!vs_act) else flag_error(0, "vsync left its off level while blanked");
        end
        if (full_cycle && !fc_seen) begin
            fc_seen = 1'b1;
            obs[1]++;
            assert (cyc == warmup_cycles()) else note_mismatch(1, warmup_cycles(), cyc);
        end
        if (fc_seen) begin
            assert (full_cycle) else flag_error(1, "full_cycle dropped after warm-up");
            // horizontal sync and draw area
            if (hs_act && !hs_prev) begin
                if (hs_have) begin
                    obs[2]++;
                    assert (now - hs_edge == H_TOTAL)
                        else note_mismatch(2, H_TOTAL, now - hs_edge);
                end
                hs_edge = now;
                hs_have = 1'b1;
                hs_len = 0;
            end
            if (hs_act) begin
                hs_len++;
            end else if (hs_prev && hs_have) begin
                assert (hs_len == H_SYNC_W) else note_mismatch(2, H_SYNC_W, hs_len);
            end
            if (draw_area && !da_prev) begin
                if (hs_have) begin
                    assert (now - hs_edge == DA_OFFSET)
                        else note_mismatch(2, DA_OFFSET, now - hs_edge);
                end
                da_len = 0;
                da_valid = 1'b1;
            end
            if (draw_area) begin
                da_len++;
            end else if (da_prev && da_valid) begin
                assert (da_len == H_VIS) else note_mismatch(2, H_VIS, da_len);
            end
            // vertical sync and window segment count
            if (vs_act && !vs_prev) begin
                assert (seg_k == V_CAP_END - V_CAP_START)
                    else note_mismatch(5, V_CAP_END - V_CAP_START, seg_k);
                seg_k = 0;
                if (vs_have) begin
                    obs[3]++;
                    assert (now - vs_edge == H_TOTAL * V1 || now - vs_edge == H_TOTAL * V2)
                        else flag_error(3, "vsync period matches neither field total");
                    assert (now - vs_edge != vs_gap_prev)
                        else flag_error(3, "successive vsync periods did not alternate");
                    vs_gap_prev = now - vs_edge;
                end
                vs_edge = now;
                vs_have = 1'b1;
                vs_len = 0;
            end
            if (vs_act) begin
                vs_len++;
            end else if (vs_prev && vs_have) begin
                assert (vs_len == V_SYNC_W * H_TOTAL)
                    else note_mismatch(3, V_SYNC_W * H_TOTAL, vs_len);
            end
            // pixel runs and row bases
            if (video_out != '0) begin
                assert (draw_area) else flag_error(5, "pixel shown outside the visible area");
                assert (video_out[23:14] == TAG)
                    else note_mismatch(4, int'(TAG), int'(video_out[23:14]));
                if (!px_prev_nz) begin
                    obs[5]++;
                    exp_addr = ((seg_k / 2) * L) % WORDS;
                    assert (addr - addr % L == exp_addr)
                        else note_mismatch(5, exp_addr, addr - addr % L);
                    // even lines restart the column at the row base
                    if (seg_k % 2 == 0) begin
                        assert (addr == exp_addr) else note_mismatch(4, exp_addr, addr);
                    end
                    if (hs_have) begin
                        assert (now - hs_edge == SEG_OFFSET)
                            else note_mismatch(5, SEG_OFFSET, now - hs_edge);
                    end
                    seg_k++;
                    seg_len = 0;
                    run_len = 0;
                end else if (addr != px_addr) begin
                    obs[4]++;
                    exp_addr = px_addr - px_addr % L + (px_addr % L + 1) % L;
                    assert (run_len == REP) else note_mismatch(4, REP, run_len);
                    assert (addr == exp_addr) else note_mismatch(4, exp_addr, addr);
                    run_len = 0;
                end
                run_len++;
                seg_len++;
                px_addr = addr;
            end else if (px_prev_nz) begin
                assert (run_len == REP) else note_mismatch(4, REP, run_len);
                assert (seg_len == H_CAP_END - H_CAP_START)
                    else note_mismatch(5, H_CAP_END - H_CAP_START, seg_len);
            end
        end
        hs_prev = hs_act;
        vs_prev = vs_act;
        da_prev = draw_area;
        px_prev_nz = (video_out != '0);
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        int delay;
        int total;
        names = '{"reset_idle", "warmup", "horizontal", "vertical",
                  "pixel_repeat", "rows_blanking"};
        reset = 1'b1;
        start = 1'b0;
        counting = 1'b0;
        cfg = '0;
        cfg.h_total = coord_t'(H_TOTAL);
        cfg.h_visible = coord_t'(H_VIS);
        cfg.h_sync_start = coord_t'(H_SYNC_START);
        cfg.h_sync_width = coord_t'(H_SYNC_W);
        cfg.h_capture_start = coord_t'(H_CAP_START);
        cfg.h_capture_end = coord_t'(H_CAP_END);
        cfg.v_total_1 = coord_t'(V1);
        cfg.v_total_2 = coord_t'(V2);
        cfg.v_visible = 12'd16;
        cfg.v_sync_start = 12'd17;
        cfg.v_sync_width = coord_t'(V_SYNC_W);
        cfg.v_capture_start = coord_t'(V_CAP_START);
        cfg.v_capture_end = coord_t'(V_CAP_END);
        cfg.h_sync_on = 1'b0;
        cfg.v_sync_on = 1'b1;
        cfg.line_length = ram_addr_t'(L);
        cfg.ram_words = ram_addr_t'(WORDS);
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        delay = $random(seed) & 32'h0f;
        repeat (delay + 2) @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        counting = 1'b1;
        wait (full_cycle);
        repeat (2 * H_TOTAL * (V1 + V2)) @(negedge clock);
        total = 0;
        for (int t = 0; t < 6; t++) begin
            if (obs[t] == 0) begin
                flag_error(t, "no events reached this check");
            end
            $display("test %s: %0d checks, %0d errors", names[t], obs[t], err[t]);
            total += err[t];
        end
        $display("tests 6, errors %0d", total);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog sized from warm-up plus four frames
    initial begin
        repeat (warmup_cycles() + 2 * H_TOTAL * (V1 + V2) + 200) @(posedge clock);
        $display("timeout: the run did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
